/* verilog/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;   // data, address and instruction
    typedef logic [4:0]  rv32i_reg;
    typedef logic [6:0]  rv32i_opcode;

    localparam rv32i_opcode op_reg   = 7'b0110011;
    localparam rv32i_opcode op_imm   = 7'b0010011;
    localparam rv32i_opcode op_lui   = 7'b0110111;
    localparam rv32i_opcode op_load  = 7'b0000011;
    localparam rv32i_opcode op_store = 7'b0100011;

    // funct3 values of the ALU group
    localparam logic [2:0] f3_add  = 3'b000;   // add, sub
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;   // srl, sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub and sra

    localparam int ALU_OP_BITS = 4;
    typedef logic [ALU_OP_BITS-1:0] alu_ops;

    localparam alu_ops alu_add    = 4'd0;
    localparam alu_ops alu_sub    = 4'd1;
    localparam alu_ops alu_and    = 4'd2;
    localparam alu_ops alu_or     = 4'd3;
    localparam alu_ops alu_xor    = 4'd4;
    localparam alu_ops alu_sll    = 4'd5;
    localparam alu_ops alu_srl    = 4'd6;
    localparam alu_ops alu_sra    = 4'd7;
    localparam alu_ops alu_slt    = 4'd8;
    localparam alu_ops alu_sltu   = 4'd9;
    localparam alu_ops alu_pass_b = 4'd10;  // lui

    localparam int CONTROL_WORD_SIZE = 9;
    typedef logic [CONTROL_WORD_SIZE-1:0] control_word;   // all zero is a bubble

    // bit positions inside control_word
    localparam int cw_regwrite   = 0;
    localparam int cw_memread    = 1;
    localparam int cw_memwrite   = 2;
    localparam int cw_alusrc_imm = 3;
    localparam int cw_wb_mem     = 4;
    localparam int cw_aluop_lsb  = 5;   // aluop in [8:5]

endpackage

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_stall,
    input  wire rv32i_pkg::rv32i_word i_imem_rdata,
    output rv32i_pkg::rv32i_word      o_imem_address,
    output logic                      o_imem_read,
    output rv32i_pkg::rv32i_word      o_instr_id,
    output logic                      o_valid_id
);

    rv32i_pkg::rv32i_word pc;

    assign o_imem_address = pc;
    assign o_imem_read    = !i_stall;   // no fetch while decode holds

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (!i_stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID, valid cleared on reset so decode sends bubbles
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid_id <= 1'b0;
        end else if (!i_stall) begin
            o_valid_id <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_instr_id <= i_imem_rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/control_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  wire rv32i_pkg::rv32i_opcode i_opcode,
    input  wire logic [2:0]             i_funct3,
    input  wire logic [6:0]             i_funct7,
    output rv32i_pkg::control_word      o_cw
);

    rv32i_pkg::alu_ops alu_f;
    logic              alt;

    assign alt = (i_funct7 == rv32i_pkg::f7_alt);

    // alu operation from funct3, shared by reg and imm forms
    always_comb begin
        case (i_funct3)
            rv32i_pkg::f3_add: begin
                // addi has no sub form
                if (alt && i_opcode == rv32i_pkg::op_reg) begin
                    alu_f = rv32i_pkg::alu_sub;
                end else begin
                    alu_f = rv32i_pkg::alu_add;
                end
            end
            rv32i_pkg::f3_sll:  alu_f = rv32i_pkg::alu_sll;
            rv32i_pkg::f3_slt:  alu_f = rv32i_pkg::alu_slt;
            rv32i_pkg::f3_sltu: alu_f = rv32i_pkg::alu_sltu;
            rv32i_pkg::f3_xor:  alu_f = rv32i_pkg::alu_xor;
            rv32i_pkg::f3_sr:   alu_f = alt ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            rv32i_pkg::f3_or:   alu_f = rv32i_pkg::alu_or;
            rv32i_pkg::f3_and:  alu_f = rv32i_pkg::alu_and;
            default:            alu_f = rv32i_pkg::alu_add;
        endcase
    end

    always_comb begin
        o_cw = '0;   // unknown opcode stays a no-op
        case (i_opcode)
            rv32i_pkg::op_reg: begin
                o_cw[rv32i_pkg::cw_regwrite] = 1'b1;
                o_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS] = alu_f;
            end
            rv32i_pkg::op_imm: begin
                o_cw[rv32i_pkg::cw_regwrite]   = 1'b1;
                o_cw[rv32i_pkg::cw_alusrc_imm] = 1'b1;
                o_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS] = alu_f;
            end
            rv32i_pkg::op_lui: begin
                o_cw[rv32i_pkg::cw_regwrite]   = 1'b1;
                o_cw[rv32i_pkg::cw_alusrc_imm] = 1'b1;
                o_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS] =
                    rv32i_pkg::alu_pass_b;
            end
            rv32i_pkg::op_load: begin
                o_cw[rv32i_pkg::cw_regwrite]   = 1'b1;
                o_cw[rv32i_pkg::cw_memread]    = 1'b1;
                o_cw[rv32i_pkg::cw_alusrc_imm] = 1'b1;
                o_cw[rv32i_pkg::cw_wb_mem]     = 1'b1;
                o_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS] = rv32i_pkg::alu_add;
            end
            rv32i_pkg::op_store: begin
                o_cw[rv32i_pkg::cw_memwrite]   = 1'b1;
                o_cw[rv32i_pkg::cw_alusrc_imm] = 1'b1; // address = rs1 + s_imm
                o_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS] = rv32i_pkg::alu_add;
            end
            default: o_cw = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_we,
    input  wire rv32i_pkg::rv32i_reg  i_waddr,
    input  wire rv32i_pkg::rv32i_word i_wdata,
    input  wire rv32i_pkg::rv32i_reg  i_raddr_a,
    input  wire rv32i_pkg::rv32i_reg  i_raddr_b,
    output rv32i_pkg::rv32i_word      o_rdata_a,
    output rv32i_pkg::rv32i_word      o_rdata_b
);

    rv32i_pkg::rv32i_word regs [32];
    logic                 wr_live;

    assign wr_live = i_we && (i_waddr != '0);   // x0 never written

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // write-through covers writeback and decode in the same cycle
    assign o_rdata_a = (wr_live && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (wr_live && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire rv32i_pkg::rv32i_word i_instr,
    input  wire logic                 i_valid,
    input  wire logic                 i_wb_en,
    input  wire rv32i_pkg::rv32i_reg  i_wb_rd,
    input  wire rv32i_pkg::rv32i_word i_wb_data,
    output logic                      o_stall,
    output rv32i_pkg::control_word    o_cw_ex,
    output rv32i_pkg::rv32i_word      o_rs1_data_ex,
    output rv32i_pkg::rv32i_word      o_rs2_data_ex,
    output rv32i_pkg::rv32i_word      o_imm_ex,
    output rv32i_pkg::rv32i_reg       o_rs1_ex,
    output rv32i_pkg::rv32i_reg       o_rs2_ex,
    output rv32i_pkg::rv32i_reg       o_rd_ex
);

    rv32i_pkg::rv32i_opcode opcode;
    rv32i_pkg::rv32i_reg    rs1, rs2, rd;
    rv32i_pkg::rv32i_word   imm, rs1_data, rs2_data;
    rv32i_pkg::control_word cw;
    logic                   uses_rs1, uses_rs2;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    always_comb begin
        case (opcode)
            rv32i_pkg::op_store: imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            rv32i_pkg::op_lui:   imm = {i_instr[31:12], 12'b0};
            default:             imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    control_rom control_rom_inst (
        .i_opcode (opcode),
        .i_funct3 (i_instr[14:12]),
        .i_funct7 (i_instr[31:25]),
        .o_cw     (cw)
    );

    regfile regfile_inst (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_we      (i_wb_en),
        .i_waddr   (i_wb_rd),
        .i_wdata   (i_wb_data),
        .i_raddr_a (rs1),
        .i_raddr_b (rs2),
        .o_rdata_a (rs1_data),
        .o_rdata_b (rs2_data)
    );

    // rs2 field is immediate bits for I-type, so only reg and store count
    assign uses_rs1 = (opcode != rv32i_pkg::op_lui);
    assign uses_rs2 = (opcode == rv32i_pkg::op_reg) || (opcode == rv32i_pkg::op_store);

    // load in ID/EX feeding this instruction
    assign o_stall = i_valid && o_cw_ex[rv32i_pkg::cw_memread] && (o_rd_ex != '0) &&
                     ((uses_rs1 && o_rd_ex == rs1) || (uses_rs2 && o_rd_ex == rs2));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cw_ex <= '0;
        end else if (o_stall || !i_valid) begin
            o_cw_ex <= '0;   // bubble
        end else begin
            o_cw_ex <= cw;
        end
    end

    always_ff @(posedge clk) begin
        o_rs1_data_ex <= rs1_data;
        o_rs2_data_ex <= rs2_data;
        o_imm_ex      <= imm;
        o_rs1_ex      <= rs1;
        o_rs2_ex      <= rs2;
        o_rd_ex       <= rd;
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    input  wire rv32i_pkg::control_word i_cw,
    input  wire rv32i_pkg::rv32i_word   i_rs1_data,
    input  wire rv32i_pkg::rv32i_word   i_rs2_data,
    input  wire rv32i_pkg::rv32i_word   i_imm,
    input  wire rv32i_pkg::rv32i_reg    i_rs1,
    input  wire rv32i_pkg::rv32i_reg    i_rs2,
    input  wire rv32i_pkg::rv32i_reg    i_rd,
    input  wire logic                   i_mem_regwrite,
    input  wire rv32i_pkg::rv32i_reg    i_mem_rd,
    input  wire rv32i_pkg::rv32i_word   i_mem_alu,
    input  wire logic                   i_wb_en,
    input  wire rv32i_pkg::rv32i_reg    i_wb_rd,
    input  wire rv32i_pkg::rv32i_word   i_wb_data,
    output rv32i_pkg::control_word      o_cw_mem,
    output rv32i_pkg::rv32i_word        o_alu_mem,
    output rv32i_pkg::rv32i_word        o_store_mem,
    output rv32i_pkg::rv32i_reg         o_rd_mem
);

    rv32i_pkg::rv32i_word src_a, src_b, op_b, alu_out;
    rv32i_pkg::alu_ops    aluop;
    logic [4:0]           shamt;

    // forwarding, memory stage beats writeback, x0 never forwards
    always_comb begin
        if (i_mem_regwrite && i_mem_rd != '0 && i_mem_rd == i_rs1) begin
            src_a = i_mem_alu;
        end else if (i_wb_en && i_wb_rd != '0 && i_wb_rd == i_rs1) begin
            src_a = i_wb_data;
        end else begin
            src_a = i_rs1_data;
        end

        if (i_mem_regwrite && i_mem_rd != '0 && i_mem_rd == i_rs2) begin
            src_b = i_mem_alu;
        end else if (i_wb_en && i_wb_rd != '0 && i_wb_rd == i_rs2) begin
            src_b = i_wb_data;
        end else begin
            src_b = i_rs2_data;
        end
    end

    assign op_b  = i_cw[rv32i_pkg::cw_alusrc_imm] ? i_imm : src_b;
    assign aluop = i_cw[rv32i_pkg::cw_aluop_lsb +: rv32i_pkg::ALU_OP_BITS];
    assign shamt = op_b[4:0];

    always_comb begin
        case (aluop)
            rv32i_pkg::alu_add:    alu_out = src_a + op_b;
            rv32i_pkg::alu_sub:    alu_out = src_a - op_b;
            rv32i_pkg::alu_and:    alu_out = src_a & op_b;
            rv32i_pkg::alu_or:     alu_out = src_a | op_b;
            rv32i_pkg::alu_xor:    alu_out = src_a ^ op_b;
            rv32i_pkg::alu_sll:    alu_out = src_a << shamt;
            rv32i_pkg::alu_srl:    alu_out = src_a >> shamt;
            rv32i_pkg::alu_sra:    alu_out = $unsigned($signed(src_a) >>> shamt);
            rv32i_pkg::alu_slt:    alu_out = {31'b0, $signed(src_a) < $signed(op_b)};
            rv32i_pkg::alu_sltu:   alu_out = {31'b0, src_a < op_b};
            rv32i_pkg::alu_pass_b: alu_out = op_b;
            default:               alu_out = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cw_mem <= '0;
        end else begin
            o_cw_mem <= i_cw;
        end
    end

    always_ff @(posedge clk) begin
        o_alu_mem   <= alu_out;
        o_store_mem <= src_b;     // forwarded rs2, not the immediate
        o_rd_mem    <= i_rd;
    end

endmodule

`default_nettype wire

/* verilog/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    input  wire rv32i_pkg::control_word i_cw,
    input  wire rv32i_pkg::rv32i_word   i_alu,
    input  wire rv32i_pkg::rv32i_word   i_store,
    input  wire rv32i_pkg::rv32i_reg    i_rd,
    input  wire rv32i_pkg::rv32i_word   i_dmem_rdata,
    output rv32i_pkg::rv32i_word        o_dmem_address,
    output rv32i_pkg::rv32i_word        o_dmem_wdata,
    output logic                        o_dmem_read,
    output logic                        o_dmem_write,
    output logic [3:0]                  o_byte_en,
    output logic                        o_mem_regwrite,
    output rv32i_pkg::rv32i_reg         o_mem_rd,
    output rv32i_pkg::rv32i_word        o_mem_alu,
    output logic                        o_wb_en,
    output rv32i_pkg::rv32i_reg         o_wb_rd,
    output rv32i_pkg::rv32i_word        o_wb_data
);

    // data port, one strobe cycle per access
    assign o_dmem_address = i_alu;
    assign o_dmem_wdata   = i_store;
    assign o_dmem_read    = i_cw[rv32i_pkg::cw_memread];
    assign o_dmem_write   = i_cw[rv32i_pkg::cw_memwrite];
    assign o_byte_en      = {4{o_dmem_read | o_dmem_write}};   // word accesses only

    // back to execute for forwarding
    assign o_mem_regwrite = i_cw[rv32i_pkg::cw_regwrite];
    assign o_mem_rd       = i_rd;
    assign o_mem_alu      = i_alu;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
        end else begin
            o_wb_en <= i_cw[rv32i_pkg::cw_regwrite];
        end
    end

    always_ff @(posedge clk) begin
        o_wb_rd   <= i_rd;
        o_wb_data <= i_cw[rv32i_pkg::cw_wb_mem] ? i_dmem_rdata : i_alu;
    end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire rv32i_pkg::rv32i_word i_i_mem_rdata,
    output rv32i_pkg::rv32i_word      o_i_mem_address,
    output logic                      o_i_mem_read,
    input  wire rv32i_pkg::rv32i_word i_d_mem_rdata,
    output rv32i_pkg::rv32i_word      o_d_mem_address,
    output rv32i_pkg::rv32i_word      o_d_mem_wdata,
    output logic                      o_d_mem_read,
    output logic                      o_d_mem_write,
    output logic [3:0]                o_mem_byte_en
);

    // IF/ID
    rv32i_pkg::rv32i_word   instr_id;
    logic                   valid_id, stall;
    // ID/EX
    rv32i_pkg::control_word cw_ex;
    rv32i_pkg::rv32i_word   rs1_data_ex, rs2_data_ex, imm_ex;
    rv32i_pkg::rv32i_reg    rs1_ex, rs2_ex, rd_ex;
    // EX/MEM
    rv32i_pkg::control_word cw_mem;
    rv32i_pkg::rv32i_word   alu_mem, store_mem;
    rv32i_pkg::rv32i_reg    rd_mem;
    // forwarding and writeback
    logic                   mem_regwrite, wb_en;
    rv32i_pkg::rv32i_reg    mem_rd, wb_rd;
    rv32i_pkg::rv32i_word   mem_alu, wb_data;

    fetch_stage fetch_stage_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_stall        (stall),
        .i_imem_rdata   (i_i_mem_rdata),
        .o_imem_address (o_i_mem_address),
        .o_imem_read    (o_i_mem_read),
        .o_instr_id     (instr_id),
        .o_valid_id     (valid_id)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_instr       (instr_id),
        .i_valid       (valid_id),
        .i_wb_en       (wb_en),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .o_stall       (stall),
        .o_cw_ex       (cw_ex),
        .o_rs1_data_ex (rs1_data_ex),
        .o_rs2_data_ex (rs2_data_ex),
        .o_imm_ex      (imm_ex),
        .o_rs1_ex      (rs1_ex),
        .o_rs2_ex      (rs2_ex),
        .o_rd_ex       (rd_ex)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_cw           (cw_ex),
        .i_rs1_data     (rs1_data_ex),
        .i_rs2_data     (rs2_data_ex),
        .i_imm          (imm_ex),
        .i_rs1          (rs1_ex),
        .i_rs2          (rs2_ex),
        .i_rd           (rd_ex),
        .i_mem_regwrite (mem_regwrite),
        .i_mem_rd       (mem_rd),
        .i_mem_alu      (mem_alu),
        .i_wb_en        (wb_en),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_cw_mem       (cw_mem),
        .o_alu_mem      (alu_mem),
        .o_store_mem    (store_mem),
        .o_rd_mem       (rd_mem)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_cw           (cw_mem),
        .i_alu          (alu_mem),
        .i_store        (store_mem),
        .i_rd           (rd_mem),
        .i_dmem_rdata   (i_d_mem_rdata),
        .o_dmem_address (o_d_mem_address),
        .o_dmem_wdata   (o_d_mem_wdata),
        .o_dmem_read    (o_d_mem_read),
        .o_dmem_write   (o_d_mem_write),
        .o_byte_en      (o_mem_byte_en),
        .o_mem_regwrite (mem_regwrite),
        .o_mem_rd       (mem_rd),
        .o_mem_alu      (mem_alu),
        .o_wb_en        (wb_en),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data)
    );

endmodule

`default_nettype wire

/* sim/datapath_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_chk (
    input wire logic clk,
    input wire logic i_rst,
    input wire logic i_fetch_read,
    input wire logic i_dmem_read,
    input wire logic i_dmem_write
);

    // one data access kind per cycle
    strobe_exclusive: assert property (@(posedge clk) disable iff (i_rst)
        !(i_dmem_read && i_dmem_write))
        else $error("data read and write strobes high together");

    first_cycle_quiet: assert property (@(posedge clk)
        $fell(i_rst) |-> !i_dmem_read && !i_dmem_write && i_fetch_read)
        else $error("strobes wrong in the first cycle after reset");

    // a load-use stall costs a single cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (i_rst)
        !i_fetch_read |=> i_fetch_read)
        else $error("fetch strobe low for more than one cycle");

endmodule

bind datapath datapath_chk datapath_chk_inst (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_fetch_read (o_i_mem_read),
    .i_dmem_read  (o_d_mem_read),
    .i_dmem_write (o_d_mem_write)
);

`default_nettype wire

/* sim/tb_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;

    localparam int                   imem_words    = 256;
    localparam int                   dmem_words    = 256;
    localparam int                   timeout_slack = 40;
    localparam rv32i_pkg::rv32i_word nop_word      = 32'h0000_0013;   // addi x0, x0, 0
    localparam string                cases_file    = "sim/program_cases.txt";

    logic                 clk;
    logic                 rst;
    rv32i_pkg::rv32i_word imem_rdata, imem_address;
    logic                 imem_read;
    rv32i_pkg::rv32i_word dmem_rdata, dmem_address, dmem_wdata;
    logic                 dmem_read, dmem_write;
    logic [3:0]           byte_en;

    rv32i_pkg::rv32i_word imem      [imem_words];
    rv32i_pkg::rv32i_word dmem      [dmem_words];
    rv32i_pkg::rv32i_word dmem_init [dmem_words];   // reloaded into dmem on reset
    rv32i_pkg::rv32i_word exp_addr  [$];
    rv32i_pkg::rv32i_word exp_data  [$];

    int n_words       = 0;
    int n_stores      = 0;
    int stores_seen   = 0;
    int cycle_count   = 0;
    bit run_passed    = 1'b0;
    bit fail_reported = 1'b0;

    datapath datapath_inst (
        .clk             (clk),
        .i_rst           (rst),
        .i_i_mem_rdata   (imem_rdata),
        .o_i_mem_address (imem_address),
        .o_i_mem_read    (imem_read),
        .i_d_mem_rdata   (dmem_rdata),
        .o_d_mem_address (dmem_address),
        .o_d_mem_wdata   (dmem_wdata),
        .o_d_mem_read    (dmem_read),
        .o_d_mem_write   (dmem_write),
        .o_mem_byte_en   (byte_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories answer in the same cycle and only to a read strobe
    assign imem_rdata = (imem_read && imem_address[31:2] < 30'(n_words)) ?
                        imem[imem_address[9:2]] : nop_word;
    assign dmem_rdata = dmem_read ? dmem[dmem_address[9:2]] : '0;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[8'(i)] <= dmem_init[8'(i)];
            end
        end else if (dmem_write) begin
            dmem[dmem_address[9:2]] <= dmem_wdata;   // all byte lanes
        end
    end

    task automatic report_fail();
        if (!fail_reported) begin
            fail_reported = 1'b1;
            $display("TEST FAIL");
        end
    endtask

    task automatic abort_run();
        report_fail();
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_store_addr(input rv32i_pkg::rv32i_word expected,
                                    input rv32i_pkg::rv32i_word actual);
        if (actual !== expected) begin
            $display("Error at %0t: store %0d address expected %h, got %h",
                     $time, stores_seen, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_store_data(input rv32i_pkg::rv32i_word expected,
                                    input rv32i_pkg::rv32i_word actual);
        if (actual !== expected) begin
            $display("Error at %0t: store %0d data expected %h, got %h",
                     $time, stores_seen, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte_en(input logic [3:0] expected, input logic [3:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: store %0d byte enables expected %b, got %b",
                     $time, stores_seen, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_fetch_addr(input rv32i_pkg::rv32i_word expected,
                                    input rv32i_pkg::rv32i_word actual);
        if (actual !== expected) begin
            $display("Error at %0t: fetch address expected %h, got %h",
                     $time, expected, actual);
            abort_run();
        end
    endtask

    // I word, D addr data, S addr data; lines starting with # are skipped
    task automatic load_cases();
        int                   fd;
        int                   cnt;
        string                line;
        rv32i_pkg::rv32i_word v1;
        rv32i_pkg::rv32i_word v2;
        for (int i = 0; i < dmem_words; i++) begin
            dmem_init[8'(i)] = 32'hc0de_0000 ^ (i << 2);   // byte address pattern
        end
        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", cases_file);
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (cnt > 0 && line.len() > 2 && line.getc(0) != "#") begin
                    case (line.getc(0))
                        "I": begin
                            cnt = $sscanf(line.substr(2, line.len() - 1), "%h", v1);
                            if (n_words < imem_words) begin
                                imem[8'(n_words)] = v1;
                                n_words++;
                            end
                        end
                        "D": begin
                            cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h", v1, v2);
                            dmem_init[v1[9:2]] = v2;
                        end
                        "S": begin
                            cnt = $sscanf(line.substr(2, line.len() - 1), "%h %h", v1, v2);
                            exp_addr.push_back(v1);
                            exp_data.push_back(v2);
                        end
                        default: begin
                            $display("unknown line in the case file: %s", line);
                            abort_run();
                        end
                    endcase
                end
            end
            $fclose(fd);
            n_stores = exp_addr.size();
        end
    endtask

    // outputs settle by mid-cycle
    always @(negedge clk) begin
        if (!rst && dmem_write) begin
            if (stores_seen >= n_stores) begin
                $display("a store to %h happened after the last expected one", dmem_address);
                abort_run();
            end else begin
                check_store_addr(exp_addr[stores_seen], dmem_address);
                check_store_data(exp_data[stores_seen], dmem_wdata);
                check_byte_en(4'hf, byte_en);
                stores_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 2 * n_words + timeout_slack) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycle_count, stores_seen, n_stores);
            abort_run();
        end
    end

    initial begin
        rst = 1'b1;
        load_cases();
        if (n_stores == 0) begin
            $display("the case file holds no expected stores");
            abort_run();
        end else begin
            repeat (3) @(posedge clk);
            #1 rst = 1'b0;
            @(negedge clk);
            check_fetch_addr(32'h0, imem_address);
            wait (stores_seen == n_stores);
            repeat (2) @(posedge clk);   // catch any stray store
            run_passed = 1'b1;
            $display("TEST PASS");
            $finish;
        end
    end

    final begin
        if (!run_passed) begin
            report_fail();
        end
    end

endmodule

`default_nettype wire

/* sim/program_cases.txt */
# I word | D byte address, data | S byte address, data in store order
# all values hex
I ff900093  # addi x1, x0, -7
I 12345137  # lui  x2, 0x12345
I 00300193  # addi x3, x0, 3
I 40308233  # sub  x4, x1, x3
I 10402023  # sw   x4, 0x100(x0)
I 4030d2b3  # sra  x5, x1, x3
I 10502223  # sw   x5, 0x104(x0)
I 0030d333  # srl  x6, x1, x3
I 10602423  # sw   x6, 0x108(x0)
I 0030a3b3  # slt  x7, x1, x3
I 10702623  # sw   x7, 0x10c(x0)
I 0030b433  # sltu x8, x1, x3
I 10802823  # sw   x8, 0x110(x0)
I 001144b3  # xor  x9, x2, x1
I 10902a23  # sw   x9, 0x114(x0)
I 00316533  # or   x10, x2, x3
I 10a02c23  # sw   x10, 0x118(x0)
I 001175b3  # and  x11, x2, x1
I 10b02e23  # sw   x11, 0x11c(x0)
I 00319633  # sll  x12, x3, x3
I 12c02023  # sw   x12, 0x120(x0)
I 005206b3  # add  x13, x4, x5
I 12d02223  # sw   x13, 0x124(x0)
I 4010d713  # srai x14, x1, 1
I fff74793  # xori x15, x14, -1
I ffd72813  # slti x16, x14, -3
I 12202423  # sw   x2, 0x128(x0)
I 12f02623  # sw   x15, 0x12c(x0)
I 13002823  # sw   x16, 0x130(x0)
I 04002903  # lw   x18, 0x40(x0)
I 02390993  # addi x19, x18, 0x23
I 13302a23  # sw   x19, 0x134(x0)
I 00500013  # addi x0, x0, 5
I 12002c23  # sw   x0, 0x138(x0)
D 00000040 00001000
S 00000100 fffffff6
S 00000104 ffffffff
S 00000108 1fffffff
S 0000010c 00000001
S 00000110 00000000
S 00000114 edcbaff9
S 00000118 12345003
S 0000011c 12345000
S 00000120 00000018
S 00000124 fffffff5
S 00000128 12345000
S 0000012c 00000003
S 00000130 00000001
S 00000134 00001023
S 00000138 00000000

/* verilog.f */
verilog/rv32i_pkg.sv
verilog/fetch_stage.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/datapath.sv
sim/datapath_chk.sv
sim/tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_datapath -f verilog.f -o Vtb_datapath

./obj_dir/Vtb_datapath > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
